// ==== source/rv_pkg.sv ====
// RV32I core shared definitions
// Opcodes, ALU operations, FSM states and instruction field positions
package rv_pkg;

  localparam int DATA_SIZE = 32;

  // Bit positions inside the instruction word
  localparam int OPCODE_LSB = 0;
  localparam int RD_LSB = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int FUNCT7_B5 = 30;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_RELEASE,
    DECODE,
    EXECUTE,
    MEM_ACCESS,
    MEM_RELEASE,
    WRITEBACK
  } core_state_e;

  // Register write-back sources
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_src_e;

endpackage

// ==== source/alu.sv ====
`timescale 1ns/100ps
// Core ALU
// Add, sub, signed set-less-than, logic ops and pass-through of B, with zero flag
module alu
  import rv_pkg::*;
(
  input  logic [DATA_SIZE-1:0] a,
  input  logic [DATA_SIZE-1:0] b,
  input  alu_op_e              op,
  output logic [DATA_SIZE-1:0] y,
  output logic                 zero
);

  logic less_than;

  // Signed compare for SLT and SLTI
  assign less_than = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_SLT: begin
        y = {{(DATA_SIZE-1){1'b0}}, less_than};
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_PASS_B: begin
        y = b;
      end
      default: begin
        y = a + b;
      end
    endcase
  end

  // Branch decisions look at this after a subtract
  assign zero = (y == '0);

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/100ps
// Integer register file, 32 entries
// Two asynchronous read ports, one synchronous write port, x0 reads as zero
module register_file #(
  parameter int WIDTH = 32
) (
  input  logic             clock,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [4:0]       rd_addr1,
  input  logic [4:0]       rd_addr2,
  input  logic [4:0]       wr_addr,
  input  logic [WIDTH-1:0] wr_data,
  output logic [WIDTH-1:0] rd_data1,
  output logic [WIDTH-1:0] rd_data2
);

  logic [WIDTH-1:0] regs [32];

  // x0 is cleared by reset and never written
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

// ==== source/imm_extender.sv ====
`timescale 1ns/100ps
// Immediate extender
// Picks the I, S, B, U or J format from the opcode and sign-extends it
module imm_extender
  import rv_pkg::*;
(
  input  logic [31:0]          instruction,
  output logic [DATA_SIZE-1:0] immediate
);

  opcode_e opcode;

  assign opcode = opcode_e'(instruction[OPCODE_LSB +: 7]);

  always_comb begin
    case (opcode)
      STORE: begin
        immediate = {{(DATA_SIZE-12){instruction[31]}}, instruction[31:25],
                     instruction[11:7]};
      end
      BRANCH: begin
        immediate = {{(DATA_SIZE-13){instruction[31]}}, instruction[31], instruction[7],
                     instruction[30:25], instruction[11:8], 1'b0};
      end
      LUI: begin
        immediate = {instruction[31:12], 12'b0};
      end
      JAL: begin
        immediate = {{(DATA_SIZE-21){instruction[31]}}, instruction[31],
                     instruction[19:12], instruction[20], instruction[30:21], 1'b0};
      end
      // OP-IMM and LOAD, also harmless for R-type
      default: begin
        immediate = {{(DATA_SIZE-12){instruction[31]}}, instruction[31:20]};
      end
    endcase
  end

endmodule

// ==== source/dataflow.sv ====
`timescale 1ns/100ps
// Core dataflow
// PC, IR and operand registers around the register file, immediate extender and ALU
module dataflow
  import rv_pkg::*;
#(
  parameter logic [DATA_SIZE-1:0] RESET_PC = '0
) (
  input  logic                 clock,
  input  logic                 rst,
  // Selects and enables from the control unit
  input  logic                 alua_src,
  input  logic                 alub_src,
  input  alu_op_e              alu_op,
  input  logic                 pc_src,
  input  wb_src_e              wb_src,
  input  logic                 mem_addr_src,
  input  logic                 pc_en,
  input  logic                 ir_en,
  input  logic                 mdr_en,
  input  logic                 reg_wr_en,
  // Memory port
  input  logic [DATA_SIZE-1:0] mem_rd_data,
  output logic [DATA_SIZE-1:0] mem_addr,
  output logic [DATA_SIZE-1:0] mem_wr_data,
  // Decode information back to the control unit
  output opcode_e              opcode,
  output logic [2:0]           funct3,
  output logic                 funct7_b5,
  output logic                 zero
);

  logic [DATA_SIZE-1:0] pc;
  logic [DATA_SIZE-1:0] old_pc;
  logic [31:0]          ir;
  logic [DATA_SIZE-1:0] mdr;
  logic [DATA_SIZE-1:0] a_reg;
  logic [DATA_SIZE-1:0] b_reg;
  logic [DATA_SIZE-1:0] alu_out;
  logic                 operand_load;
  logic [DATA_SIZE-1:0] rs1_data;
  logic [DATA_SIZE-1:0] rs2_data;
  logic [DATA_SIZE-1:0] wb_data;
  logic [DATA_SIZE-1:0] immediate;
  logic [DATA_SIZE-1:0] alu_a;
  logic [DATA_SIZE-1:0] alu_b;
  logic [DATA_SIZE-1:0] alu_y;
  logic [DATA_SIZE-1:0] pc_plus_4;
  logic [DATA_SIZE-1:0] pc_target;
  logic [DATA_SIZE-1:0] link_addr;
  logic [DATA_SIZE-1:0] pc_next;

  // PC and the operand capture strobe, one cycle after the IR loads
  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= RESET_PC;
      operand_load <= 1'b0;
    end else begin
      if (pc_en) begin
        pc <= pc_next;
      end
      operand_load <= ir_en;
    end
  end

  always_ff @(posedge clock) begin
    if (ir_en) begin
      ir <= mem_rd_data[31:0];
      old_pc <= pc;
    end
    if (mdr_en) begin
      mdr <= mem_rd_data;
    end
    // A and B hold until the next instruction, so store data stays put
    if (operand_load) begin
      a_reg <= rs1_data;
      b_reg <= rs2_data;
    end
    alu_out <= alu_y;
  end

  register_file #(
    .WIDTH(DATA_SIZE)
  ) i_register_file (
    .clock   (clock),
    .rst     (rst),
    .wr_en   (reg_wr_en),
    .rd_addr1(ir[RS1_LSB +: 5]),
    .rd_addr2(ir[RS2_LSB +: 5]),
    .wr_addr (ir[RD_LSB +: 5]),
    .wr_data (wb_data),
    .rd_data1(rs1_data),
    .rd_data2(rs2_data)
  );

  imm_extender i_imm_extender (
    .instruction(ir),
    .immediate  (immediate)
  );

  assign alu_a = alua_src ? old_pc : a_reg;
  assign alu_b = alub_src ? immediate : b_reg;

  alu i_alu (
    .a   (alu_a),
    .b   (alu_b),
    .op  (alu_op),
    .y   (alu_y),
    .zero(zero)
  );

  // Next PC: sequential on fetch, target from the fetched instruction's address
  assign pc_plus_4 = pc + DATA_SIZE'(4);
  assign pc_target = old_pc + immediate;
  assign link_addr = old_pc + DATA_SIZE'(4);
  assign pc_next = pc_src ? pc_target : pc_plus_4;

  always_comb begin
    case (wb_src)
      WB_MEM: wb_data = mdr;
      WB_PC4: wb_data = link_addr;
      default: wb_data = alu_out;
    endcase
  end

  assign mem_addr = mem_addr_src ? alu_out : pc;
  assign mem_wr_data = b_reg;

  assign opcode = opcode_e'(ir[OPCODE_LSB +: 7]);
  assign funct3 = ir[FUNCT3_LSB +: 3];
  assign funct7_b5 = ir[FUNCT7_B5];

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/100ps
// Multicycle control unit
// Sequences fetch, decode, execute, memory and write-back, owns the memory handshake
module control_unit
  import rv_pkg::*;
(
  input  logic       clock,
  input  logic       rst,
  input  logic       mem_ack,
  input  opcode_e    opcode,
  input  logic [2:0] funct3,
  input  logic       funct7_b5,
  input  logic       zero,
  output logic       mem_req,
  output logic       mem_we,
  output logic       alua_src,
  output logic       alub_src,
  output alu_op_e    alu_op,
  output logic       pc_src,
  output logic       pc_en,
  output logic       ir_en,
  output logic       mdr_en,
  output wb_src_e    wb_src,
  output logic       reg_wr_en,
  output logic       mem_addr_src
);

  core_state_e state;
  core_state_e next_state;
  logic        req_ack;
  logic        branch_taken;
  logic        in_execute;

  assign req_ack = mem_req & mem_ack;
  assign in_execute = (state == EXECUTE);
  // funct3 bit 0 tells BNE from BEQ
  assign branch_taken = funct3[0] ? ~zero : zero;

  always_comb begin
    next_state = state;
    case (state)
      FETCH: if (req_ack) next_state = FETCH_RELEASE;
      FETCH_RELEASE: if (!mem_ack) next_state = DECODE;
      DECODE: next_state = EXECUTE;
      EXECUTE: begin
        case (opcode)
          LOAD, STORE: next_state = MEM_ACCESS;
          LUI, OP_IMM, OP: next_state = WRITEBACK;
          // Branches, JAL and unknown opcodes are done here
          default: next_state = FETCH;
        endcase
      end
      MEM_ACCESS: if (req_ack) next_state = MEM_RELEASE;
      MEM_RELEASE: begin
        if (!mem_ack) begin
          next_state = (opcode == LOAD) ? WRITEBACK : FETCH;
        end
      end
      default: next_state = FETCH;
    endcase
  end

  // Request rises on entry to a memory state and drops on the ack
  always_ff @(posedge clock) begin
    if (rst) begin
      state <= FETCH;
      mem_req <= 1'b0;
      mem_we <= 1'b0;
    end else begin
      state <= next_state;
      mem_req <= (next_state == FETCH) || (next_state == MEM_ACCESS);
      mem_we <= (next_state == MEM_ACCESS) && (opcode == STORE);
    end
  end

  always_comb begin
    alu_op = ALU_ADD;
    case (opcode)
      LUI: alu_op = ALU_PASS_B;
      BRANCH: alu_op = ALU_SUB;
      OP_IMM, OP: begin
        case (funct3)
          3'b000: alu_op = (opcode == OP && funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          default: alu_op = ALU_ADD;
        endcase
      end
      default: alu_op = ALU_ADD;
    endcase
  end

  assign alua_src = (opcode == JAL);
  assign alub_src = (opcode != OP) && (opcode != BRANCH);

  assign ir_en = (state == FETCH) && req_ack;
  assign pc_src = in_execute;
  assign pc_en = ir_en ||
                 (in_execute && ((opcode == JAL) || (opcode == BRANCH && branch_taken)));
  assign mdr_en = (state == MEM_ACCESS) && req_ack && (opcode == LOAD);
  assign reg_wr_en = (state == WRITEBACK) || (in_execute && opcode == JAL);
  assign mem_addr_src = (state == MEM_ACCESS);

  always_comb begin
    case (opcode)
      LOAD: wb_src = WB_MEM;
      JAL: wb_src = WB_PC4;
      default: wb_src = WB_ALU;
    endcase
  end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/100ps
// RV32I multicycle core
// Control unit and dataflow sharing one req/ack memory port
module rv_core
  import rv_pkg::*;
#(
  parameter logic [DATA_SIZE-1:0] RESET_PC = '0
) (
  input  logic                 clock,
  input  logic                 rst,
  output logic                 mem_req,
  output logic                 mem_we,
  output logic [DATA_SIZE-1:0] mem_addr,
  output logic [DATA_SIZE-1:0] mem_wr_data,
  input  logic [DATA_SIZE-1:0] mem_rd_data,
  input  logic                 mem_ack
);

  logic       alua_src;
  logic       alub_src;
  alu_op_e    alu_op;
  logic       pc_src;
  wb_src_e    wb_src;
  logic       mem_addr_src;
  logic       pc_en;
  logic       ir_en;
  logic       mdr_en;
  logic       reg_wr_en;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic       zero;

  control_unit i_control_unit (
    .clock       (clock),
    .rst         (rst),
    .mem_ack     (mem_ack),
    .opcode      (opcode),
    .funct3      (funct3),
    .funct7_b5   (funct7_b5),
    .zero        (zero),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .alua_src    (alua_src),
    .alub_src    (alub_src),
    .alu_op      (alu_op),
    .pc_src      (pc_src),
    .pc_en       (pc_en),
    .ir_en       (ir_en),
    .mdr_en      (mdr_en),
    .wb_src      (wb_src),
    .reg_wr_en   (reg_wr_en),
    .mem_addr_src(mem_addr_src)
  );

  dataflow #(
    .RESET_PC(RESET_PC)
  ) i_dataflow (
    .clock       (clock),
    .rst         (rst),
    .alua_src    (alua_src),
    .alub_src    (alub_src),
    .alu_op      (alu_op),
    .pc_src      (pc_src),
    .wb_src      (wb_src),
    .mem_addr_src(mem_addr_src),
    .pc_en       (pc_en),
    .ir_en       (ir_en),
    .mdr_en      (mdr_en),
    .reg_wr_en   (reg_wr_en),
    .mem_rd_data (mem_rd_data),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .opcode      (opcode),
    .funct3      (funct3),
    .funct7_b5   (funct7_b5),
    .zero        (zero)
  );

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/100ps
// Behavioral word memory for the core testbench
// Answers the four-phase req/ack handshake with random ack and release delays
module mem_model
  import rv_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic                 clock,
  input  logic                 rst,
  input  logic                 req,
  input  logic                 we,
  input  logic [DATA_SIZE-1:0] addr,
  input  logic [DATA_SIZE-1:0] wr_data,
  output logic [DATA_SIZE-1:0] rd_data,
  output logic                 ack
);

  localparam int IDX_BITS = $clog2(MEM_WORDS);

  logic [DATA_SIZE-1:0] mem [MEM_WORDS];
  logic [IDX_BITS-1:0]  idx;
  int                   phase;
  int                   delay;

  assign idx = addr[IDX_BITS+1:2];

  // Preload hook for the testbench
  task automatic load_word(input int unsigned word_idx, input logic [DATA_SIZE-1:0] data);
    mem[word_idx] = data;
  endtask

  always @(posedge clock) begin
    if (rst) begin
      ack <= 1'b0;
      rd_data <= '0;
      phase <= 0;
      delay <= 0;
    end else begin
      case (phase)
        // Idle, waiting for a request
        0: begin
          if (req) begin
            delay <= int'($urandom_range(3, 0));
            phase <= 1;
          end
        end
        1: begin
          if (delay == 0) begin
            ack <= 1'b1;
            rd_data <= mem[idx];
            if (we) begin
              mem[idx] <= wr_data;
            end
            phase <= 2;
          end else begin
            delay <= delay - 1;
          end
        end
        // Ack held until the core drops req
        2: begin
          if (!req) begin
            delay <= int'($urandom_range(3, 0));
            phase <= 3;
          end
        end
        default: begin
          if (delay == 0) begin
            ack <= 1'b0;
            phase <= 0;
          end else begin
            delay <= delay - 1;
          end
        end
      endcase
    end
  end

endmodule

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/100ps
// Testbench for the multicycle RV32I core
// Runs a fixed program and checks its stores and the memory handshake
module tb_rv_core;

  localparam logic [31:0] RESET_PC = 32'h0000_0100;
  localparam int MEM_WORDS = 256;
  localparam int NUM_INSTR = 32;
  localparam int NUM_STORES = 13;
  localparam logic [31:0] SELF_ADDR = RESET_PC + 32'(4 * (NUM_INSTR - 1));
  // Budget of 12 cycles per instruction scaled by the worst memory delay
  localparam int TIMEOUT_CYCLES = 10 + NUM_INSTR * 12 * 4;

  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;

  logic        clock;
  logic        rst;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wr_data;
  logic [31:0] mem_rd_data;
  logic        mem_ack;

  logic [31:0] prog [NUM_INSTR];
  logic [31:0] exp_addr [NUM_STORES];
  logic [31:0] exp_data [NUM_STORES];
  string       exp_name [NUM_STORES];
  int          store_idx;
  int          self_fetches;
  int          mismatch_errors;
  int          protocol_errors;
  logic        first_fetch_seen;
  logic        prev_req;
  logic        prev_ack;
  logic        prev_we;
  logic [31:0] prev_addr;
  logic [31:0] prev_wdata;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) i_rv_core (
    .clock      (clock),
    .rst        (rst),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wr_data(mem_wr_data),
    .mem_rd_data(mem_rd_data),
    .mem_ack    (mem_ack)
  );

  mem_model #(
    .MEM_WORDS(MEM_WORDS)
  ) i_mem (
    .clock  (clock),
    .rst    (rst),
    .req    (mem_req),
    .we     (mem_we),
    .addr   (mem_addr),
    .wr_data(mem_wr_data),
    .rd_data(mem_rd_data),
    .ack    (mem_ack)
  );

  always #20 clock = ~clock;

  // RV32I encoders built from the instruction formats
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_store(input int i, input string name, input logic [31:0] addr,
                           input logic [31:0] data);
    exp_name[i] = name;
    exp_addr[i] = addr;
    exp_data[i] = data;
  endtask

  task automatic build_program();
    prog[0] = enc_i(12'd768, 5'd0, 3'b000, 5'd10, OPC_OPIMM);
    prog[1] = {20'h12345, 5'd1, OPC_LUI};
    prog[2] = enc_s(12'd0, 5'd1, 5'd10);
    prog[3] = enc_i(-12'sd5, 5'd0, 3'b000, 5'd2, OPC_OPIMM);
    prog[4] = enc_s(12'd4, 5'd2, 5'd10);
    prog[5] = enc_i(12'd7, 5'd0, 3'b000, 5'd3, OPC_OPIMM);
    prog[6] = enc_r(7'b0100000, 5'd2, 5'd3, 3'b000, 5'd4);
    prog[7] = enc_s(12'd8, 5'd4, 5'd10);
    prog[8] = enc_r(7'd0, 5'd2, 5'd3, 3'b100, 5'd5);
    prog[9] = enc_s(12'd12, 5'd5, 5'd10);
    prog[10] = enc_r(7'd0, 5'd2, 5'd3, 3'b110, 5'd6);
    prog[11] = enc_s(12'd16, 5'd6, 5'd10);
    prog[12] = enc_r(7'd0, 5'd2, 5'd3, 3'b111, 5'd7);
    prog[13] = enc_s(12'd20, 5'd7, 5'd10);
    prog[14] = enc_r(7'd0, 5'd3, 5'd2, 3'b010, 5'd8);
    prog[15] = enc_s(12'd24, 5'd8, 5'd10);
    prog[16] = enc_i(-12'sd1, 5'd3, 3'b010, 5'd9, OPC_OPIMM);
    prog[17] = enc_s(12'd28, 5'd9, 5'd10);
    prog[18] = enc_i(12'h0f5, 5'd3, 3'b110, 5'd11, OPC_OPIMM);
    prog[19] = enc_i(12'h0ff, 5'd2, 3'b111, 5'd12, OPC_OPIMM);
    prog[20] = enc_s(12'd32, 5'd11, 5'd10);
    prog[21] = enc_s(12'd36, 5'd12, 5'd10);
    prog[22] = enc_i(12'd0, 5'd10, 3'b010, 5'd13, OPC_LOAD);
    prog[23] = enc_s(12'd40, 5'd13, 5'd10);
    // Taken BEQ skips the marker at 0x32c and untaken BNE falls into 0x330
    prog[24] = enc_b(13'd8, 5'd3, 5'd3, 3'b000);
    prog[25] = enc_s(12'd44, 5'd3, 5'd10);
    prog[26] = enc_b(13'd8, 5'd3, 5'd3, 3'b001);
    prog[27] = enc_s(12'd48, 5'd3, 5'd10);
    prog[28] = enc_j(21'd8, 5'd14);
    prog[29] = enc_s(12'd52, 5'd3, 5'd10);
    prog[30] = enc_s(12'd56, 5'd14, 5'd10);
    prog[31] = enc_j(21'd0, 5'd0);
    add_store(0, "lui", 32'h300, 32'h1234_5000);
    add_store(1, "addi_neg", 32'h304, 32'hffff_fffb);
    add_store(2, "sub", 32'h308, 32'h0000_000c);
    add_store(3, "xor", 32'h30c, 32'hffff_fffc);
    add_store(4, "or", 32'h310, 32'hffff_ffff);
    add_store(5, "and", 32'h314, 32'h0000_0003);
    add_store(6, "slt", 32'h318, 32'h0000_0001);
    add_store(7, "slti", 32'h31c, 32'h0000_0000);
    add_store(8, "ori", 32'h320, 32'h0000_00f7);
    add_store(9, "andi", 32'h324, 32'h0000_00fb);
    add_store(10, "lw_sw", 32'h328, 32'h1234_5000);
    add_store(11, "bne_marker", 32'h330, 32'h0000_0007);
    add_store(12, "jal_link", 32'h338, 32'h0000_0174);
    // Background fill unique to every word
    for (int i = 0; i < MEM_WORDS; i++) begin
      i_mem.load_word(i, {~16'(i), 16'(i)});
    end
    for (int i = 0; i < NUM_INSTR; i++) begin
      i_mem.load_word(RESET_PC / 4 + i, prog[i]);
    end
  endtask

  // Store traffic and handshake checks on pre-edge values
  always @(posedge clock) begin
    if (rst) begin
      assert (mem_req !== 1'b1) else begin
        $display("mem_req is high during reset");
        protocol_errors++;
      end
    end else begin
      if (mem_req && !prev_req) begin
        assert (!mem_ack) else begin
          $display("mem_req rose while mem_ack was still high");
          protocol_errors++;
        end
        if (!first_fetch_seen) begin
          first_fetch_seen = 1'b1;
          assert (mem_addr == RESET_PC) else begin
            $display("Mismatch first_fetch: expected %h, actual %h", RESET_PC, mem_addr);
            mismatch_errors++;
          end
        end
      end
      if (mem_req && prev_req) begin
        assert (mem_addr === prev_addr && mem_we === prev_we && mem_wr_data === prev_wdata)
        else begin
          $display("Address, write enable or write data changed while mem_req was high");
          protocol_errors++;
        end
      end
      if (!mem_req && prev_req) begin
        assert (prev_ack) else begin
          $display("mem_req fell before mem_ack was seen high");
          protocol_errors++;
        end
      end
      if (mem_req && mem_ack && mem_we) begin
        if (store_idx >= NUM_STORES) begin
          $display("Unexpected extra store to %h", mem_addr);
          protocol_errors++;
        end else begin
          assert (mem_addr == exp_addr[store_idx]) else begin
            $display("Mismatch %s address: expected %h, actual %h", exp_name[store_idx],
                     exp_addr[store_idx], mem_addr);
            mismatch_errors++;
          end
          assert (mem_wr_data == exp_data[store_idx]) else begin
            $display("Mismatch %s: expected %h, actual %h", exp_name[store_idx],
                     exp_data[store_idx], mem_wr_data);
            mismatch_errors++;
          end
        end
        store_idx++;
      end
      // A fetch handshake of the self-jump address
      if (mem_req && mem_ack && !mem_we && mem_addr == SELF_ADDR) begin
        self_fetches++;
      end
    end
    prev_req = mem_req;
    prev_ack = mem_ack;
    prev_we = mem_we;
    prev_addr = mem_addr;
    prev_wdata = mem_wr_data;
  end

  initial begin
    #(TIMEOUT_CYCLES * 40);
    $display("Watchdog expired after %0d cycles without reaching the self-jump",
             TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h3999_e195));
    clock = 1'b0;
    rst = 1'b1;
    store_idx = 0;
    self_fetches = 0;
    mismatch_errors = 0;
    protocol_errors = 0;
    first_fetch_seen = 1'b0;
    prev_req = 1'b0;
    prev_ack = 1'b0;
    prev_we = 1'b0;
    prev_addr = '0;
    prev_wdata = '0;
    build_program();
    repeat (10) @(posedge clock);
    rst <= 1'b0;
    wait (self_fetches >= 3);
    @(posedge clock);
    assert (store_idx == NUM_STORES) else begin
      $display("Only %0d of %0d stores arrived before the self-jump", store_idx, NUM_STORES);
      protocol_errors++;
    end
    $display("Errors: %0d mismatches, %0d protocol errors", mismatch_errors, protocol_errors);
    if (mismatch_errors == 0 && protocol_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
source/rv_pkg.sv
source/alu.sv
source/register_file.sv
source/imm_extender.sv
source/dataflow.sv
source/control_unit.sv
source/rv_core.sv
verif/mem_model.sv
verif/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o tb_rv_core
./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
